/* logic/mmu_defs.svh */
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// TLB geometry
`define TLB_NUM     16
`define TLB_IDX_W   4
`define VPPN_W      19
`define PPN_W       20
`define ASID_W      10

// Page size codes, equal to the in-page offset width
`define PS_4K       12
`define PS_4M       21

// Exception codes
`define ECODE_NONE  6'h00
`define ECODE_PIL   6'h01   // Load, page invalid
`define ECODE_PIS   6'h02   // Store, page invalid
`define ECODE_PIF   6'h03   // Fetch, page invalid
`define ECODE_PME   6'h04   // Page modified
`define ECODE_PPI   6'h07   // Privilege violation
`define ECODE_TLBR  6'h3F   // TLB refill

// Direct map window register fields
`define DMW_PLV0_BIT  0
`define DMW_PLV3_BIT  3
`define DMW_MAT_LSB   4
`define DMW_PSEG_LSB  25
`define DMW_VSEG_LSB  29

`endif

/* logic/mmu_pkg.sv */
`default_nettype none

`include "mmu_defs.svh"

package mmu_pkg;

    typedef struct packed {
        logic [`PPN_W-1:0] ppn;
        logic [1:0]        plv;
        logic [1:0]        mat;
        logic              d;   // Dirty, writes allowed
        logic              v;
    } tlb_page_t;

    typedef struct packed {
        logic               e;
        logic [`VPPN_W-1:0] vppn;
        logic [5:0]         ps;
        logic [`ASID_W-1:0] asid;
        logic               g;
        tlb_page_t          page0;
        tlb_page_t          page1;
    } tlb_entry_t;

    // Same layout as the DMW register
    typedef struct packed {
        logic [2:0]                                 vseg;
        logic [`DMW_VSEG_LSB-`DMW_PSEG_LSB-4:0]     rsv_hi;
        logic [2:0]                                 pseg;
        logic [`DMW_PSEG_LSB-`DMW_MAT_LSB-3:0]      rsv_mid;
        logic [1:0]                                 mat;
        logic                                       plv3;
        logic [`DMW_PLV3_BIT-`DMW_PLV0_BIT-2:0]     rsv_lo;
        logic                                       plv0;
    } dmw_t;

    typedef struct packed {
        logic               da;
        logic               pg;
        logic [1:0]         plv;
        logic [`ASID_W-1:0] asid;
        dmw_t               dmw0;
        dmw_t               dmw1;
    } mode_t;

    typedef struct packed {
        logic [`VPPN_W-1:0] vppn;
        logic               odd;
        logic [`PS_4K-1:0]  offset;
    } va_4k_t;

    typedef struct packed {
        logic [`VPPN_W-`PS_4M+`PS_4K-1:0] vppn_hi;
        logic                             odd;
        logic [`PS_4M-1:0]                offset;
    } va_4m_t;

    typedef union packed {
        va_4k_t p4k;
        va_4m_t p4m;
    } va_u;

    typedef struct packed {
        logic [31:0] pa;
        logic [5:0]  ecode;
        logic [1:0]  mat;
    } xlate_rsp_t;

    typedef struct packed {
        logic [2:0]         op;
        logic [`ASID_W-1:0] asid;
        logic [`VPPN_W-1:0] vppn;
    } inv_req_t;

    // Page-size aware vppn compare, 4 MB pages ignore the low 9 bits
    function automatic logic vppn_match(tlb_entry_t ent, logic [`VPPN_W-1:0] vppn);
        return (ent.ps == 6'(`PS_4M)) ?
            (ent.vppn[`VPPN_W-1:`PS_4M-`PS_4K] == vppn[`VPPN_W-1:`PS_4M-`PS_4K]) :
            (ent.vppn == vppn);
    endfunction

endpackage

`default_nettype wire

/* logic/tlb_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module tlb_array (
    input  logic                                clk,
    input  logic                                reset,
    // Write port
    input  logic                                we,
    input  logic [`TLB_IDX_W-1:0]               w_index,
    input  mmu_pkg::tlb_entry_t                 w_entry,
    // Read port
    input  logic [`TLB_IDX_W-1:0]               r_index,
    output mmu_pkg::tlb_entry_t                 r_entry,
    // Invalidate
    input  logic                                inv_valid,
    input  mmu_pkg::inv_req_t                   inv_req,
    output mmu_pkg::tlb_entry_t [`TLB_NUM-1:0]  entries
);
    import mmu_pkg::*;

    logic [`TLB_NUM-1:0] inv_hit;

    assign r_entry = entries[r_index];

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            case (inv_req.op)
                3'd0, 3'd1: inv_hit[i] = 1'b1;
                3'd2:       inv_hit[i] = entries[i].g;
                3'd3:       inv_hit[i] = !entries[i].g;
                3'd4:       inv_hit[i] = !entries[i].g && (entries[i].asid == inv_req.asid);
                3'd5: begin
                    inv_hit[i] = !entries[i].g && (entries[i].asid == inv_req.asid) &&
                                 vppn_match(entries[i], inv_req.vppn);
                end
                3'd6: begin
                    inv_hit[i] = (entries[i].g || (entries[i].asid == inv_req.asid)) &&
                                 vppn_match(entries[i], inv_req.vppn);
                end
                default:    inv_hit[i] = 1'b0;  // Reserved ops
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                entries[i].e <= 1'b0;
            end
        end else begin
            if (inv_valid) begin
                for (int i = 0; i < `TLB_NUM; i++) begin
                    if (inv_hit[i]) begin
                        entries[i].e <= 1'b0;
                    end
                end
            end
            // Last assignment, so a write beats a same-cycle invalidate
            if (we) begin
                entries[w_index] <= w_entry;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/tlb_match.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module tlb_match (
    input  mmu_pkg::tlb_entry_t [`TLB_NUM-1:0]  entries,
    input  mmu_pkg::va_u                        va,
    input  logic [`ASID_W-1:0]                  asid,
    output logic                                hit,
    output logic [`TLB_IDX_W-1:0]               hit_index,
    output mmu_pkg::tlb_page_t                  page,
    output logic [5:0]                          ps
);
    import mmu_pkg::*;

    logic [`TLB_NUM-1:0] hit_vec;
    tlb_entry_t          sel;
    logic                odd;

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            hit_vec[i] = entries[i].e &&
                         (entries[i].g || (entries[i].asid == asid)) &&
                         vppn_match(entries[i], va.p4k.vppn);
        end
    end

    // Scan downwards so the lowest index wins
    always_comb begin
        hit       = 1'b0;
        hit_index = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit       = 1'b1;
                hit_index = `TLB_IDX_W'(i);
            end
        end
    end

    assign sel  = entries[hit_index];
    assign odd  = (sel.ps == 6'(`PS_4M)) ? va.p4m.odd : va.p4k.odd;  // Bit 21 or bit 12
    assign page = odd ? sel.page1 : sel.page0;
    assign ps   = sel.ps;

endmodule

`default_nettype wire

/* logic/addr_xlate.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module addr_xlate #(
    parameter bit FETCH_PORT = 1'b0
) (
    input  mmu_pkg::tlb_entry_t [`TLB_NUM-1:0]  entries,
    input  mmu_pkg::mode_t                      mode,
    input  logic [31:0]                         va,
    input  logic                                store,
    output mmu_pkg::xlate_rsp_t                 rsp
);
    import mmu_pkg::*;

    va_u       va_dec;
    logic      tlb_hit;
    tlb_page_t page;
    logic [5:0] page_ps;
    logic      dmw0_hit;
    logic      dmw1_hit;
    logic      is_store;

    function automatic logic dmw_hit(dmw_t w, logic [1:0] plv, logic [2:0] seg);
        return (w.vseg == seg) &&
               (((plv == 2'd0) && w.plv0) || ((plv == 2'd3) && w.plv3));
    endfunction

    assign va_dec   = va;
    assign is_store = !FETCH_PORT && store;   // Fetches never store
    assign dmw0_hit = mode.pg && dmw_hit(mode.dmw0, mode.plv, va[31:29]);
    assign dmw1_hit = mode.pg && dmw_hit(mode.dmw1, mode.plv, va[31:29]);

    tlb_match u_match (
        .entries   (entries),
        .va        (va_dec),
        .asid      (mode.asid),
        .hit       (tlb_hit),
        .hit_index (),          // Only the page matters here
        .page      (page),
        .ps        (page_ps)
    );

    always_comb begin
        if (mode.da) begin
            rsp.pa    = va;
            rsp.ecode = `ECODE_NONE;
            rsp.mat   = 2'b00;
        end else if (dmw0_hit) begin
            rsp.pa    = {mode.dmw0.pseg, va[28:0]};
            rsp.ecode = `ECODE_NONE;
            rsp.mat   = mode.dmw0.mat;
        end else if (dmw1_hit) begin
            rsp.pa    = {mode.dmw1.pseg, va[28:0]};
            rsp.ecode = `ECODE_NONE;
            rsp.mat   = mode.dmw1.mat;
        end else begin
            if (page_ps == 6'(`PS_4M)) begin
                rsp.pa = {page.ppn[`PPN_W-1:`PS_4M-`PS_4K], va_dec.p4m.offset};
            end else begin
                rsp.pa = {page.ppn, va_dec.p4k.offset};
            end
            rsp.mat = page.mat;
            if (!tlb_hit) begin
                rsp.ecode = `ECODE_TLBR;
            end else if (!page.v) begin
                rsp.ecode = FETCH_PORT ? `ECODE_PIF : (is_store ? `ECODE_PIS : `ECODE_PIL);
            end else if (mode.plv > page.plv) begin
                rsp.ecode = `ECODE_PPI;
            end else if (is_store && !page.d) begin
                rsp.ecode = `ECODE_PME;
            end else begin
                rsp.ecode = `ECODE_NONE;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mmu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module mmu_top (
    input  logic                    clk,
    input  logic                    reset,
    input  mmu_pkg::mode_t          mode,
    // Translation ports
    input  logic [31:0]             fetch_va,
    input  logic [31:0]             data_va,
    input  logic                    data_store,
    // TLB maintenance
    input  logic                    tlb_we,
    input  logic [`TLB_IDX_W-1:0]   tlb_w_index,
    input  mmu_pkg::tlb_entry_t     tlb_w_entry,
    input  logic [`TLB_IDX_W-1:0]   tlb_r_index,
    output mmu_pkg::tlb_entry_t     tlb_r_entry,
    input  logic                    inv_valid,
    input  mmu_pkg::inv_req_t       inv_req,
    // Results
    output mmu_pkg::xlate_rsp_t     fetch_rsp,
    output mmu_pkg::xlate_rsp_t     data_rsp
);
    import mmu_pkg::*;

    tlb_entry_t [`TLB_NUM-1:0] entries;

    tlb_array u_tlb_array (
        .clk       (clk),
        .reset     (reset),
        .we        (tlb_we),
        .w_index   (tlb_w_index),
        .w_entry   (tlb_w_entry),
        .r_index   (tlb_r_index),
        .r_entry   (tlb_r_entry),
        .inv_valid (inv_valid),
        .inv_req   (inv_req),
        .entries   (entries)
    );

    addr_xlate #(.FETCH_PORT(1'b1)) u_fetch_xlate (
        .entries (entries),
        .mode    (mode),
        .va      (fetch_va),
        .store   (),            // Unused on the fetch side
        .rsp     (fetch_rsp)
    );

    addr_xlate #(.FETCH_PORT(1'b0)) u_data_xlate (
        .entries (entries),
        .mode    (mode),
        .va      (data_va),
        .store   (data_store),
        .rsp     (data_rsp)
    );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* dv/tb_mmu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module tb_mmu;
    import mmu_pkg::*;

    localparam int PLAN_CYCLES = 16 + 24 + 40 + 112 + 40 + 7 * 84 + 20;
    localparam logic [`ASID_W-1:0] ASID_A = 10'h155;
    localparam logic [`ASID_W-1:0] ASID_B = 10'h2aa;

    logic                      clk;
    logic                      reset;
    mode_t                     mode;
    logic [31:0]               fetch_va;
    logic [31:0]               data_va;
    logic                      data_store;
    logic                      tlb_we;
    logic [`TLB_IDX_W-1:0]     tlb_w_index;
    tlb_entry_t                tlb_w_entry;
    logic [`TLB_IDX_W-1:0]     tlb_r_index;
    tlb_entry_t                tlb_r_entry;
    logic                      inv_valid;
    inv_req_t                  inv_req;
    xlate_rsp_t                fetch_rsp;
    xlate_rsp_t                data_rsp;

    tlb_entry_t                shadow [`TLB_NUM];
    integer                    seed = 32'hf4f7;
    int                        errors = 0;
    string                     test_name = "idle";
    logic                      lookup_en;
    logic                      code_en;
    logic [5:0]                exp_fcode;
    logic [5:0]                exp_dcode;
    logic [1:0]                read_en;   // 1 for the full entry and 2 for the e bit

    tb_clock u_clock (.clk(clk), .reset(reset));

    mmu_top u_mmu_top (
        .clk(clk), .reset(reset), .mode(mode),
        .fetch_va(fetch_va), .data_va(data_va), .data_store(data_store),
        .tlb_we(tlb_we), .tlb_w_index(tlb_w_index), .tlb_w_entry(tlb_w_entry),
        .tlb_r_index(tlb_r_index), .tlb_r_entry(tlb_r_entry),
        .inv_valid(inv_valid), .inv_req(inv_req),
        .fetch_rsp(fetch_rsp), .data_rsp(data_rsp)
    );

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic page_match(tlb_entry_t ent, logic [`VPPN_W-1:0] vppn);
        if (ent.ps == 6'(`PS_4M))
            return ent.vppn[18:9] == vppn[18:9];  // 4 MB pages drop the low 9 bits
        return ent.vppn == vppn;
    endfunction

    function automatic logic win_hit(dmw_t w, logic [1:0] plv, logic [31:0] va);
        return (w.vseg == va[31:29]) && ((plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3));
    endfunction

    function automatic xlate_rsp_t ref_xlate(mode_t m, logic [31:0] va, logic st, logic fetch);
        xlate_rsp_t r;
        tlb_page_t  pg;
        logic       hit;
        logic       big;
        logic       wr;
        int         idx;
        r   = '0;
        hit = 1'b0;
        idx = 0;
        wr  = st && !fetch;
        if (m.da) begin
            r.pa = va;
            return r;
        end
        if (m.pg && win_hit(m.dmw0, m.plv, va)) begin
            r.pa  = {m.dmw0.pseg, va[28:0]};
            r.mat = m.dmw0.mat;
            return r;
        end
        if (m.pg && win_hit(m.dmw1, m.plv, va)) begin
            r.pa  = {m.dmw1.pseg, va[28:0]};
            r.mat = m.dmw1.mat;
            return r;
        end
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (shadow[i].e && (shadow[i].g || shadow[i].asid == m.asid) &&
                page_match(shadow[i], va[31:13])) begin
                hit = 1'b1;
                idx = i;
            end
        end
        if (!hit) begin
            r.ecode = `ECODE_TLBR;
            return r;
        end
        big   = shadow[idx].ps == 6'(`PS_4M);
        pg    = (big ? va[21] : va[12]) ? shadow[idx].page1 : shadow[idx].page0;
        r.pa  = big ? {pg.ppn[19:9], va[20:0]} : {pg.ppn, va[11:0]};
        r.mat = pg.mat;
        if (!pg.v)
            r.ecode = fetch ? `ECODE_PIF : (wr ? `ECODE_PIS : `ECODE_PIL);
        else if (m.plv > pg.plv)
            r.ecode = `ECODE_PPI;
        else if (wr && !pg.d)
            r.ecode = `ECODE_PME;
        return r;
    endfunction

    function automatic tlb_entry_t rand_entry(int i);
        tlb_entry_t ent;
        logic [31:0] r;
        r          = rnd();
        ent.e      = 1'b1;
        ent.vppn   = {4'(i), r[14:0]};   // Index in the top bits keeps tags unique
        ent.ps     = r[15] ? 6'(`PS_4M) : 6'(`PS_4K);
        ent.asid   = r[16] ? ASID_A : ASID_B;
        ent.g      = r[17];
        r          = rnd();
        ent.page0  = {r[19:0], r[21:20], r[23:22], r[24], r[25] | r[26]};
        r          = rnd();
        ent.page1  = {r[19:0], r[21:20], r[23:22], r[24], r[25] | r[26]};
        return ent;
    endfunction

    function automatic logic [31:0] va_in(tlb_entry_t ent);
        logic [31:0] v;
        v = rnd();
        if (ent.ps == 6'(`PS_4M))
            v[31:22] = ent.vppn[18:9];
        else
            v[31:13] = ent.vppn;
        return v;
    endfunction

    function automatic void shadow_inv(inv_req_t q);
        logic kill;
        for (int i = 0; i < `TLB_NUM; i++) begin
            case (q.op)
                3'd0, 3'd1: kill = 1'b1;
                3'd2:       kill = shadow[i].g;
                3'd3:       kill = !shadow[i].g;
                3'd4:       kill = !shadow[i].g && shadow[i].asid == q.asid;
                3'd5:       kill = !shadow[i].g && shadow[i].asid == q.asid &&
                                   page_match(shadow[i], q.vppn);
                3'd6:       kill = (shadow[i].g || shadow[i].asid == q.asid) &&
                                   page_match(shadow[i], q.vppn);
                default:    kill = 1'b0;
            endcase
            if (kill)
                shadow[i].e = 1'b0;
        end
    endfunction

    task automatic set_mode(mode_t m);
        @(posedge clk);
        mode      <= m;
        lookup_en <= 1'b0;
        read_en   <= 2'd0;
    endtask

    task automatic drive_write(int i, tlb_entry_t ent);
        @(posedge clk);
        tlb_we      <= 1'b1;
        tlb_w_index <= 4'(i);
        tlb_w_entry <= ent;
        lookup_en   <= 1'b0;
        read_en     <= 2'd0;
        @(posedge clk);
        tlb_we      <= 1'b0;
        shadow[i]   = ent;
    endtask

    task automatic drive_inv(inv_req_t q);
        @(posedge clk);
        inv_valid <= 1'b1;
        inv_req   <= q;
        lookup_en <= 1'b0;
        read_en   <= 2'd0;
        @(posedge clk);
        inv_valid <= 1'b0;
        shadow_inv(q);
    endtask

    task automatic read_sweep(string name, logic [1:0] kind);
        for (int i = 0; i < `TLB_NUM; i++) begin
            @(posedge clk);
            test_name   <= name;
            tlb_r_index <= 4'(i);
            lookup_en   <= 1'b0;
            read_en     <= kind;
        end
    endtask

    task automatic drive_lookup(string name, logic [31:0] fva, logic [31:0] dva, logic st,
                                logic chk, logic [5:0] fexp, logic [5:0] dexp);
        @(posedge clk);
        test_name  <= name;
        fetch_va   <= fva;
        data_va    <= dva;
        data_store <= st;
        lookup_en  <= 1'b1;
        read_en    <= 2'd0;
        code_en    <= chk;
        exp_fcode  <= fexp;
        exp_dcode  <= dexp;
    endtask

    task automatic lookup_random(string name);
        logic [31:0] r;
        r = rnd();
        drive_lookup(name, va_in(shadow[r[3:0]]), va_in(shadow[r[7:4]]), r[8], 1'b0, 6'd0, 6'd0);
    endtask

    task automatic fill_table();
        for (int i = 0; i < `TLB_NUM; i++)
            drive_write(i, rand_entry(i));
    endtask

    task automatic check_rsp(string port, xlate_rsp_t exp, xlate_rsp_t act);
        // Address and mat are undefined on a refill
        if ((exp.ecode == `ECODE_TLBR && act.ecode != exp.ecode) ||
            (exp.ecode != `ECODE_TLBR && act != exp)) begin
            $display("mismatch %s %s exp %h act %h", test_name, port, exp, act);
            errors++;
        end
    endtask

    // Samples mid-cycle where all inputs are settled
    always @(negedge clk) begin
        if (!reset && lookup_en) begin
            check_rsp("fetch", ref_xlate(mode, fetch_va, 1'b0, 1'b1), fetch_rsp);
            check_rsp("data", ref_xlate(mode, data_va, data_store, 1'b0), data_rsp);
            if (code_en && fetch_rsp.ecode != exp_fcode) begin
                $display("mismatch %s fetch ecode exp %h act %h", test_name, exp_fcode,
                         fetch_rsp.ecode);
                errors++;
            end
            if (code_en && data_rsp.ecode != exp_dcode) begin
                $display("mismatch %s data ecode exp %h act %h", test_name, exp_dcode,
                         data_rsp.ecode);
                errors++;
            end
        end
        if (!reset && read_en == 2'd1 && tlb_r_entry != shadow[tlb_r_index]) begin
            $display("mismatch %s read exp %h act %h", test_name, shadow[tlb_r_index],
                     tlb_r_entry);
            errors++;
        end
        if (!reset && read_en == 2'd2 && tlb_r_entry.e != 1'b0) begin
            $display("mismatch %s read e exp 0 act %b", test_name, tlb_r_entry.e);
            errors++;
        end
    end

    initial begin
        #(20 * PLAN_CYCLES * 10);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    initial begin
        mode_t       m;
        tlb_entry_t  ent;
        inv_req_t    q;
        logic [31:0] r;
        mode        = '0;
        fetch_va    = '0;
        data_va     = '0;
        data_store  = 1'b0;
        tlb_we      = 1'b0;
        tlb_w_index = '0;
        tlb_w_entry = '0;
        tlb_r_index = '0;
        inv_valid   = 1'b0;
        inv_req     = '0;
        lookup_en   = 1'b0;
        code_en     = 1'b0;
        exp_fcode   = '0;
        exp_dcode   = '0;
        read_en     = 2'd0;
        for (int i = 0; i < `TLB_NUM; i++)
            shadow[i] = '0;
        wait (!reset);

        read_sweep("reset_read", 2'd2);

        m    = '0;
        m.da = 1'b1;
        set_mode(m);
        for (int i = 0; i < 20; i++)
            drive_lookup("direct", rnd(), rnd(), rnd() > 32'h7fffffff, 1'b1, 6'd0, 6'd0);

        // dmw1 is enabled for level 0 only
        r = rnd();
        m = '0;
        m.pg = 1'b1;
        m.dmw0.vseg = r[2:0];
        m.dmw0.pseg = r[5:3];
        m.dmw0.mat  = r[7:6];
        m.dmw0.plv0 = 1'b1;
        m.dmw0.plv3 = 1'b1;
        m.dmw1.vseg = r[2:0] ^ 3'b101;
        m.dmw1.pseg = r[10:8];
        m.dmw1.mat  = r[12:11];
        m.dmw1.plv0 = 1'b1;
        set_mode(m);
        for (int i = 0; i < 16; i++)
            drive_lookup("window_plv0", {m.dmw0.vseg, 29'(rnd())}, {m.dmw1.vseg, 29'(rnd())},
                         1'b0, 1'b1, `ECODE_NONE, `ECODE_NONE);
        m.plv = 2'd3;
        set_mode(m);
        for (int i = 0; i < 16; i++)
            drive_lookup("window_plv3", {m.dmw0.vseg, 29'(rnd())}, {m.dmw1.vseg, 29'(rnd())},
                         1'b1, 1'b1, `ECODE_NONE, `ECODE_TLBR);

        fill_table();
        read_sweep("read_back", 2'd1);
        for (int i = 0; i < 64; i++) begin
            if (i % 16 == 0) begin
                r = rnd();
                m = '0;
                m.pg = 1'b1;
                m.plv = r[1:0];
                m.asid = r[2] ? ASID_A : ASID_B;
                set_mode(m);
            end
            lookup_random("mapped");
        end

        // One exception per step on a crafted entry 0
        m = '0;
        m.pg = 1'b1;
        m.plv = 2'd3;
        m.asid = ASID_A;
        set_mode(m);
        ent = rand_entry(0);
        ent.ps = 6'(`PS_4K);
        ent.g = 1'b0;
        ent.asid = ASID_B;
        ent.page0 = '0;
        ent.page1 = '0;
        drive_write(0, ent);
        r = va_in(ent);
        drive_lookup("exc_tlbr", r, r, 1'b0, 1'b1, `ECODE_TLBR, `ECODE_TLBR);
        ent.g = 1'b1;
        drive_write(0, ent);
        drive_lookup("exc_pil", r, r, 1'b0, 1'b1, `ECODE_PIF, `ECODE_PIL);
        drive_lookup("exc_pis", r, r, 1'b1, 1'b1, `ECODE_PIF, `ECODE_PIS);
        ent.page0.v = 1'b1;
        ent.page1.v = 1'b1;
        drive_write(0, ent);
        drive_lookup("exc_ppi", r, r, 1'b1, 1'b1, `ECODE_PPI, `ECODE_PPI);
        ent.page0.plv = 2'd3;
        ent.page1.plv = 2'd3;
        drive_write(0, ent);
        drive_lookup("exc_pme", r, r, 1'b1, 1'b1, `ECODE_NONE, `ECODE_PME);
        ent.page0.d = 1'b1;
        ent.page1.d = 1'b1;
        drive_write(0, ent);
        drive_lookup("exc_none", r, r, 1'b1, 1'b1, `ECODE_NONE, `ECODE_NONE);

        for (int op = 0; op < 7; op++) begin
            fill_table();
            r = rnd();
            q.op = 3'(op);
            q.asid = r[0] ? ASID_A : ASID_B;
            q.vppn = shadow[r[4:1]].vppn;
            drive_inv(q);
            read_sweep("inv_read", 2'd1);
            m = '0;
            m.pg = 1'b1;
            m.asid = r[5] ? ASID_A : ASID_B;
            set_mode(m);
            for (int i = 0; i < 16; i++)
                lookup_random("inv_search");
        end

        @(posedge clk);
        lookup_en <= 1'b0;
        read_en   <= 2'd0;
        @(posedge clk);
        $display("%0d errors", errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+logic
logic/mmu_pkg.sv
logic/tlb_array.sv
logic/tlb_match.sv
logic/addr_xlate.sv
logic/mmu_top.sv
dv/tb_clock.sv
dv/tb_mmu.sv

/* run.sh */
#!/bin/sh
# Build and run the MMU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_mmu -o sim_mmu

out=$(./obj_dir/sim_mmu)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
